// File: design/mist_bus_macros.svh
`ifndef MIST_BUS_MACROS_SVH
`define MIST_BUS_MACROS_SVH

// Bus widths shared by the arbiter, memory port and IO port

// Byte address on both memory and GCI side
`define MIST_ADDR_W 32

// Store word from the core
`define MIST_WORD_W 32

// Read line returned by external memory
// Two words, each swapped on its own
`define MIST_LINE_W 64

// One enable per byte of the store word
`define MIST_MASK_W 4

// Byte lane width used by the endian swap
`define MIST_BYTE_W 8

// Reads allowed in flight before both ports lock
// Keep a power of two, pointers wrap on overflow
`define MIST_OWNER_DEPTH 4

// Owner queue pointer and occupancy widths
`define MIST_OWNER_PTR_W $clog2(`MIST_OWNER_DEPTH)
`define MIST_OWNER_CNT_W $clog2(`MIST_OWNER_DEPTH + 1)

`endif

// File: design/mist_bus_pkg.sv
package mist_bus_pkg;

	// Access size on the memory and IO request
	// Encoding matches the external memory bus
	typedef enum logic [1:0] {
		// Single byte
		order_byte = 2'd0,
		// Two bytes
		order_half = 2'd1,
		// Full 32-bit word
		order_word = 2'd2,
		// No transfer size
		order_none = 2'd3
	} mem_order_t;

	// Requester that issued a read still in flight
	typedef enum logic {
		// Instruction fetch port
		owner_inst = 1'b0,
		// Data load port
		owner_data = 1'b1
	} mem_owner_t;

	// Local IO write acknowledge
	// GCI writes never return, so the core is answered here
	typedef enum logic {
		// Nothing to answer
		io_idle = 1'b0,
		// Ack strobe this cycle
		io_write_ack = 1'b1
	} io_ack_state_t;

endpackage

// File: design/mem_pipe_arbiter.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module mem_pipe_arbiter
	import mist_bus_pkg::*;
(
	input logic bus_clock,
	input logic reset,
	// Instruction fetch port
	input logic inst_req,
	output logic inst_lock,
	input logic [`MIST_ADDR_W-1:0] inst_addr,
	output logic inst_valid,
	output logic [`MIST_LINE_W-1:0] inst_data,
	// Data port, request side
	input logic data_req,
	output logic data_lock,
	input mem_order_t data_order,
	input logic [`MIST_MASK_W-1:0] data_mask,
	input logic data_rw,
	input logic [`MIST_ADDR_W-1:0] data_addr,
	input logic [`MIST_WORD_W-1:0] data_wdata,
	// Data port, return side
	output logic data_valid,
	output logic [`MIST_LINE_W-1:0] data_rdata,
	// Merged request toward the memory port
	output logic arb_req,
	output mem_order_t arb_order,
	output logic [`MIST_MASK_W-1:0] arb_mask,
	output logic arb_rw,
	output logic [`MIST_ADDR_W-1:0] arb_addr,
	output logic [`MIST_WORD_W-1:0] arb_data,
	// Lock and read return from the memory port
	input logic port_lock,
	input logic port_valid,
	input logic [`MIST_LINE_W-1:0] port_line
);
	// Owner tag per read in flight, oldest at rd_ptr
	mem_owner_t owner_q [`MIST_OWNER_DEPTH];
	logic [`MIST_OWNER_PTR_W-1:0] wr_ptr;
	logic [`MIST_OWNER_PTR_W-1:0] rd_ptr;
	logic [`MIST_OWNER_CNT_W-1:0] owner_count;
	logic owner_full;
	logic owner_empty;
	logic lock_all;
	logic data_take;
	logic inst_take;
	logic push;
	logic pop;
	mem_owner_t head_owner;

	assign owner_full = (owner_count == `MIST_OWNER_CNT_W'(`MIST_OWNER_DEPTH));
	assign owner_empty = (owner_count == '0);

	// Memory back-pressure or no free owner slot stalls both ports
	assign lock_all = port_lock || owner_full;
	assign data_lock = lock_all;
	// Data wins a tie, so fetch also sees a lock while data asks
	assign inst_lock = lock_all || data_req;

	assign data_take = data_req && !lock_all;
	assign inst_take = inst_req && !lock_all && !data_req;

	// Only reads come back, stores leave no tag
	assign push = inst_take || (data_take && !data_rw);
	// Stray return with nothing outstanding is dropped
	assign pop = port_valid && !owner_empty;
	assign head_owner = owner_q[rd_ptr];

	// Returns come back in issue order, head tag picks the port
	assign inst_valid = pop && (head_owner == owner_inst);
	assign data_valid = pop && (head_owner == owner_data);
	assign inst_data = port_line;
	assign data_rdata = port_line;

	// One-cycle strobe per accepted request
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			arb_req <= 1'b0;
		end else begin
			arb_req <= data_take || inst_take;
		end
	end

	// Request fields, loaded only on acceptance
	always_ff @(posedge bus_clock) begin
		if (data_take) begin
			arb_order <= data_order;
			arb_mask <= data_mask;
			arb_rw <= data_rw;
			arb_addr <= data_addr;
			arb_data <= data_wdata;
		end else if (inst_take) begin
			// Fetch is always a full word read
			arb_order <= order_word;
			arb_mask <= '1;
			arb_rw <= 1'b0;
			arb_addr <= inst_addr;
			arb_data <= '0;
		end
	end

	// Tag storage
	always_ff @(posedge bus_clock) begin
		if (push) begin
			owner_q[wr_ptr] <= data_take ? owner_data : owner_inst;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			owner_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: owner_count <= owner_count + 1'b1;
				2'b01: owner_count <= owner_count - 1'b1;
				default: owner_count <= owner_count;
			endcase
		end
	end

endmodule

// File: design/memory_port.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module memory_port
	import mist_bus_pkg::*;
(
	input logic bus_clock,
	input logic reset,
	// Request from the arbiter
	input logic arb_req,
	input mem_order_t arb_order,
	input logic [`MIST_MASK_W-1:0] arb_mask,
	input logic arb_rw,
	input logic [`MIST_ADDR_W-1:0] arb_addr,
	input logic [`MIST_WORD_W-1:0] arb_data,
	// Back to the arbiter
	output logic port_lock,
	output logic port_valid,
	output logic [`MIST_LINE_W-1:0] port_line,
	// External memory request
	output logic memory_req,
	output mem_order_t memory_order,
	output logic [`MIST_MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [`MIST_ADDR_W-1:0] memory_addr,
	output logic [`MIST_WORD_W-1:0] memory_data,
	// External memory lock and read return
	input logic memory_lock,
	input logic memory_valid,
	input logic [`MIST_LINE_W-1:0] memory_rdata
);
	// Request parked while memory refuses it
	logic hold_valid;
	mem_order_t hold_order;
	logic [`MIST_MASK_W-1:0] hold_mask;
	logic hold_rw;
	logic [`MIST_ADDR_W-1:0] hold_addr;
	logic [`MIST_WORD_W-1:0] hold_data;
	logic [`MIST_MASK_W-1:0] sel_mask;
	logic [`MIST_WORD_W-1:0] sel_data;

	// Byte order flip inside one word
	function automatic logic [`MIST_WORD_W-1:0] swap_bytes(input logic [`MIST_WORD_W-1:0] word);
		logic [`MIST_WORD_W-1:0] swapped;
		for (int i = 0; i < `MIST_WORD_W / `MIST_BYTE_W; i++) begin
			swapped[`MIST_BYTE_W*i +: `MIST_BYTE_W] =
				word[`MIST_WORD_W-`MIST_BYTE_W-`MIST_BYTE_W*i +: `MIST_BYTE_W];
		end
		return swapped;
	endfunction

	// Byte enables follow their bytes, so the mask is mirrored
	function automatic logic [`MIST_MASK_W-1:0] reverse_mask(input logic [`MIST_MASK_W-1:0] mask);
		logic [`MIST_MASK_W-1:0] reversed;
		for (int i = 0; i < `MIST_MASK_W; i++) begin
			reversed[i] = mask[`MIST_MASK_W-1-i];
		end
		return reversed;
	endfunction

	// Park the request when memory locks while it is on the bus
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (!hold_valid && arb_req && memory_lock) begin
			hold_valid <= 1'b1;
		end else if (hold_valid && !memory_lock) begin
			// Memory takes it on this edge
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge bus_clock) begin
		if (!hold_valid) begin
			hold_order <= arb_order;
			hold_mask <= arb_mask;
			hold_rw <= arb_rw;
			hold_addr <= arb_addr;
			hold_data <= arb_data;
		end
	end

	// Parked copy wins until memory lets go
	assign memory_req = hold_valid || arb_req;
	assign memory_order = hold_valid ? hold_order : arb_order;
	assign memory_rw = hold_valid ? hold_rw : arb_rw;
	assign memory_addr = hold_valid ? hold_addr : arb_addr;
	assign sel_mask = hold_valid ? hold_mask : arb_mask;
	assign sel_data = hold_valid ? hold_data : arb_data;
	assign memory_mask = reverse_mask(sel_mask);
	assign memory_data = swap_bytes(sel_data);

	// Arbiter must not issue while memory is locked
	assign port_lock = memory_lock;

	// Read line, each half swapped on its own, same cycle
	assign port_valid = memory_valid;
	assign port_line = {swap_bytes(memory_rdata[`MIST_LINE_W-1:`MIST_WORD_W]),
		swap_bytes(memory_rdata[`MIST_WORD_W-1:0])};

endmodule

// File: design/io_port.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module io_port
	import mist_bus_pkg::*;
(
	input logic bus_clock,
	input logic reset,
	// Core IO request
	input logic io_req,
	input mem_order_t io_order,
	input logic io_rw,
	input logic [`MIST_ADDR_W-1:0] io_addr,
	input logic [`MIST_WORD_W-1:0] io_wdata,
	// Core IO return
	output logic io_busy,
	output logic io_valid,
	output logic [`MIST_WORD_W-1:0] io_rdata,
	output logic io_fault,
	// GCI request
	output logic gci_req,
	output logic gci_rw,
	output logic [`MIST_ADDR_W-1:0] gci_addr,
	output logic [`MIST_WORD_W-1:0] gci_data,
	// GCI busy and read return
	input logic gci_busy,
	input logic gci_ret_valid,
	input logic [`MIST_WORD_W-1:0] gci_ret_data
);
	io_ack_state_t ack_state;
	logic io_take;
	logic bad_write;
	logic fwd_take;

	// GCI back-pressure passes straight to the core
	assign io_busy = gci_busy;
	assign io_take = io_req && !io_busy;
	// Writes narrower than a word are faulted
	assign bad_write = io_rw && (io_order != order_word);
	assign fwd_take = io_take && !bad_write;

	// GCI strobe holds while the bus reports busy
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			gci_req <= 1'b0;
		end else if (fwd_take) begin
			gci_req <= 1'b1;
		end else if (!gci_busy) begin
			gci_req <= 1'b0;
		end
	end

	always_ff @(posedge bus_clock) begin
		if (fwd_take) begin
			gci_rw <= io_rw;
			gci_addr <= io_addr;
			gci_data <= io_wdata;
		end
	end

	// Faulted write dies here with a one-cycle pulse
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			io_fault <= 1'b0;
		end else begin
			io_fault <= io_take && bad_write;
		end
	end

	// Local ack for good writes since GCI never answers them
	always_ff @(posedge bus_clock) begin
		if (reset) begin
			ack_state <= io_idle;
		end else begin
			case (ack_state)
				io_idle: if (fwd_take && io_rw) ack_state <= io_write_ack;
				// Back-to-back write keeps the ack for one more cycle
				io_write_ack: if (!(fwd_take && io_rw)) ack_state <= io_idle;
				default: ack_state <= io_idle;
			endcase
		end
	end

	// Read data comes from GCI whenever it arrives
	assign io_valid = (ack_state == io_write_ack) || gci_ret_valid;
	assign io_rdata = gci_ret_data;

endmodule

// File: design/mist_bus_unit.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module mist_bus_unit
	import mist_bus_pkg::*;
(
	input logic bus_clock,
	input logic reset,
	// Instruction fetch port
	input logic inst_req,
	output logic inst_lock,
	input logic [`MIST_ADDR_W-1:0] inst_addr,
	output logic inst_valid,
	output logic [`MIST_LINE_W-1:0] inst_data,
	// Data port
	input logic data_req,
	output logic data_lock,
	input mem_order_t data_order,
	input logic [`MIST_MASK_W-1:0] data_mask,
	input logic data_rw,
	input logic [`MIST_ADDR_W-1:0] data_addr,
	input logic [`MIST_WORD_W-1:0] data_wdata,
	output logic data_valid,
	output logic [`MIST_LINE_W-1:0] data_rdata,
	// External memory
	output logic memory_req,
	input logic memory_lock,
	output mem_order_t memory_order,
	output logic [`MIST_MASK_W-1:0] memory_mask,
	output logic memory_rw,
	output logic [`MIST_ADDR_W-1:0] memory_addr,
	output logic [`MIST_WORD_W-1:0] memory_data,
	input logic memory_valid,
	input logic [`MIST_LINE_W-1:0] memory_rdata,
	// Core IO
	input logic io_req,
	output logic io_busy,
	input mem_order_t io_order,
	input logic io_rw,
	input logic [`MIST_ADDR_W-1:0] io_addr,
	input logic [`MIST_WORD_W-1:0] io_wdata,
	output logic io_valid,
	output logic [`MIST_WORD_W-1:0] io_rdata,
	output logic io_fault,
	// GCI bus
	output logic gci_req,
	input logic gci_busy,
	output logic gci_rw,
	output logic [`MIST_ADDR_W-1:0] gci_addr,
	output logic [`MIST_WORD_W-1:0] gci_data,
	input logic gci_ret_valid,
	input logic [`MIST_WORD_W-1:0] gci_ret_data
);
	// Arbiter to memory port
	logic arb_req;
	mem_order_t arb_order;
	logic [`MIST_MASK_W-1:0] arb_mask;
	logic arb_rw;
	logic [`MIST_ADDR_W-1:0] arb_addr;
	logic [`MIST_WORD_W-1:0] arb_data;
	// Memory port back to arbiter
	logic port_lock;
	logic port_valid;
	logic [`MIST_LINE_W-1:0] port_line;

	mem_pipe_arbiter i_arbiter (
		.bus_clock, .reset,
		.inst_req, .inst_lock, .inst_addr, .inst_valid, .inst_data,
		.data_req, .data_lock, .data_order, .data_mask, .data_rw, .data_addr, .data_wdata,
		.data_valid, .data_rdata,
		.arb_req, .arb_order, .arb_mask, .arb_rw, .arb_addr, .arb_data,
		.port_lock, .port_valid, .port_line
	);

	// Holding register and endian swap toward memory
	memory_port i_memory_port (
		.bus_clock, .reset,
		.arb_req, .arb_order, .arb_mask, .arb_rw, .arb_addr, .arb_data,
		.port_lock, .port_valid, .port_line,
		.memory_req, .memory_order, .memory_mask, .memory_rw, .memory_addr, .memory_data,
		.memory_lock, .memory_valid, .memory_rdata
	);

	// IO path to GCI with local write ack
	io_port i_io_port (
		.bus_clock, .reset,
		.io_req, .io_order, .io_rw, .io_addr, .io_wdata,
		.io_busy, .io_valid, .io_rdata, .io_fault,
		.gci_req, .gci_rw, .gci_addr, .gci_data,
		.gci_busy, .gci_ret_valid, .gci_ret_data
	);

endmodule

// File: bench/mist_bus_unit_assertions.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module mist_bus_unit_assertions
	import mist_bus_pkg::*;
(
	input logic bus_clock,
	input logic reset,
	input logic memory_req,
	input logic memory_lock,
	input mem_order_t memory_order,
	input logic [`MIST_MASK_W-1:0] memory_mask,
	input logic memory_rw,
	input logic [`MIST_ADDR_W-1:0] memory_addr,
	input logic [`MIST_WORD_W-1:0] memory_data,
	input logic inst_valid,
	input logic data_valid,
	input logic io_req,
	input logic io_busy,
	input mem_order_t io_order,
	input logic io_rw,
	input logic io_valid,
	input logic io_fault,
	input logic gci_req,
	input logic gci_ret_valid
);
	// Locked request stays on the bus unchanged
	a_mem_hold: assert property (@(posedge bus_clock) disable iff (reset)
		memory_req && memory_lock |=> memory_req && $stable(memory_addr)
		&& $stable(memory_data) && $stable(memory_mask)
		&& $stable(memory_order) && $stable(memory_rw))
		else $error("memory request changed while memory_lock was high");

	// Fault is a single-cycle pulse
	a_fault_pulse: assert property (@(posedge bus_clock) disable iff (reset)
		io_fault |=> !io_fault)
		else $error("io_fault held longer than one cycle");

	// Local ack follows each accepted word write by exactly one cycle
	a_ack_pulse: assert property (@(posedge bus_clock) disable iff (reset)
		!gci_ret_valid |-> io_valid == $past(io_req && !io_busy && io_rw
		&& io_order == order_word))
		else $error("write acknowledge missing or held longer than one cycle");

	// First edge skipped while registers take reset
	a_reset_quiet: assert property (@(posedge bus_clock)
		reset && $past(reset) |-> !memory_req && !gci_req && !io_valid
		&& !io_fault && !inst_valid && !data_valid)
		else $error("strobe active during reset");

endmodule

bind mist_bus_unit mist_bus_unit_assertions i_assertions (.*);

// File: bench/mist_bus_unit_tb.sv
`timescale 1ns/1ns
`include "mist_bus_macros.svh"

module mist_bus_unit_tb
	import mist_bus_pkg::*;
();
	typedef enum {k_ifetch, k_dwrite, k_burst, k_iowrite, k_ioread} kind_t;
	typedef struct {
		string name;
		kind_t kind;
		logic [`MIST_ADDR_W-1:0] addr;
		logic [`MIST_WORD_W-1:0] data;
		mem_order_t order;
		logic [`MIST_MASK_W-1:0] mask;
	} test_t;

	logic bus_clock, reset, inst_req, inst_lock, inst_valid, data_req, data_lock, data_rw;
	logic data_valid, memory_req, memory_lock, memory_rw, memory_valid;
	logic io_req, io_busy, io_rw, io_valid, io_fault, gci_req, gci_busy, gci_rw, gci_ret_valid;
	logic [`MIST_ADDR_W-1:0] inst_addr, data_addr, memory_addr, io_addr, gci_addr;
	logic [`MIST_WORD_W-1:0] data_wdata, memory_data, io_wdata, io_rdata, gci_data, gci_ret_data;
	logic [`MIST_LINE_W-1:0] inst_data, data_rdata, memory_rdata;
	logic [`MIST_MASK_W-1:0] data_mask, memory_mask;
	mem_order_t data_order, memory_order, io_order;

	// Model state
	integer seed = 32'hff44f4d4;
	int cyc, lock_left, errors, gci_due;
	logic decided, gci_pend;
	logic [`MIST_ADDR_W-1:0] gci_pend_addr, rsp_addr[$];
	int rsp_due[$];
	// Observed results
	logic [`MIST_LINE_W-1:0] inst_got[$], data_got[$];
	logic [`MIST_WORD_W-1:0] wr_data[$], wr_mask[$];
	mem_order_t wr_order[$];
	int io_valid_n, io_fault_n, gci_req_n;
	logic [`MIST_WORD_W-1:0] io_got, gci_wr_addr, gci_wr_data;
	test_t tests[8];

	mist_bus_unit i_dut (.*);

	always #5 bus_clock = ~bus_clock;

	// Expected values from the endian rule
	function automatic logic [31:0] swap_word(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Model line is address over its inverse
	function automatic logic [63:0] line_of(input logic [31:0] a);
		return {swap_word(a), swap_word(~a)};
	endfunction

	// Sample pre-edge values to accept requests and log strobes
	always @(posedge bus_clock) begin
		int due;
		if (memory_req && !memory_lock) begin
			decided = 1'b0;
			if (memory_rw) begin
				wr_data.push_back(memory_data);
				wr_mask.push_back({28'd0, memory_mask});
				wr_order.push_back(memory_order);
			end else begin
				due = cyc + 1 + $unsigned($random(seed)) % 3;
				// Keep returns in issue order
				if (rsp_due.size() > 0 && due <= rsp_due[$])
					due = rsp_due[$] + 1;
				rsp_addr.push_back(memory_addr);
				rsp_due.push_back(due);
			end
		end
		if (inst_valid)
			inst_got.push_back(inst_data);
		if (data_valid)
			data_got.push_back(data_rdata);
		if (gci_req && !gci_busy) begin
			gci_req_n++;
			if (gci_rw) begin
				gci_wr_addr = gci_addr;
				gci_wr_data = gci_data;
			end else begin
				gci_pend = 1'b1;
				gci_pend_addr = gci_addr;
				gci_due = cyc + 1 + $unsigned($random(seed)) % 3;
			end
		end
		if (io_valid) begin
			io_valid_n++;
			io_got = io_rdata;
		end
		if (io_fault)
			io_fault_n++;
		cyc++;
	end

	// Memory and GCI models drive on the falling edge
	always @(negedge bus_clock) begin
		memory_valid = 1'b0;
		gci_ret_valid = 1'b0;
		if (memory_lock) begin
			lock_left--;
			if (lock_left <= 0)
				memory_lock = 1'b0;
		end else if (memory_req === 1'b1 && !decided) begin
			// 0 to 2 lock cycles per request
			decided = 1'b1;
			lock_left = $unsigned($random(seed)) % 3;
			memory_lock = (lock_left != 0);
		end
		if (rsp_due.size() > 0 && cyc >= rsp_due[0]) begin
			memory_valid = 1'b1;
			memory_rdata = {rsp_addr[0], ~rsp_addr[0]};
			void'(rsp_addr.pop_front());
			void'(rsp_due.pop_front());
		end
		if (gci_pend && cyc >= gci_due) begin
			gci_pend = 1'b0;
			gci_ret_valid = 1'b1;
			gci_ret_data = gci_pend_addr + 32'h1000;
		end
	end

	task automatic check_line(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_order(input string name, input mem_order_t exp, input mem_order_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %s actual %s", name, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	function automatic int count_of(input int which);
		case (which)
			0: return inst_got.size();
			1: return data_got.size();
			2: return wr_data.size();
			3: return io_valid_n;
			default: return io_fault_n;
		endcase
	endfunction

	// Bounded wait for a result counter
	task automatic wait_for(input string what, input int which, input int target);
		for (int t = 0; t < 100; t++) begin
			@(negedge bus_clock);
			if (count_of(which) >= target)
				return;
		end
		$display("Timed out waiting for %s", what);
		errors++;
	endtask

	// Called just after a falling edge with fields already set
	task automatic issue(input int port);
		int t;
		case (port)
			0: inst_req = 1'b1;
			1: data_req = 1'b1;
			default: io_req = 1'b1;
		endcase
		for (t = 0; t < 100; t++) begin
			#1;
			if (port == 0 ? !inst_lock : port == 1 ? !data_lock : !io_busy)
				break;
			@(negedge bus_clock);
		end
		if (t == 100) begin
			$display("Request on port %0d was never accepted", port);
			errors++;
		end
		@(negedge bus_clock);
		inst_req = 1'b0;
		data_req = 1'b0;
		io_req = 1'b0;
	endtask

	task automatic run_test(input test_t tc);
		int e0, bi, bd, bw, bv, bf, bg;
		logic [3:0] m;
		e0 = errors;
		bi = inst_got.size();
		bd = data_got.size();
		bw = wr_data.size();
		bv = io_valid_n;
		bf = io_fault_n;
		bg = gci_req_n;
		m = tc.mask;
		@(negedge bus_clock);
		case (tc.kind)
			k_ifetch: begin
				inst_addr = tc.addr;
				issue(0);
				wait_for("instruction line", 0, bi + 1);
				if (inst_got.size() > bi)
					check_line(tc.name, line_of(tc.addr), inst_got[bi]);
				check_flag({tc.name, " data_valid"}, 1'b0, data_got.size() != bd);
			end
			k_dwrite: begin
				data_addr = tc.addr;
				data_wdata = tc.data;
				data_order = tc.order;
				data_mask = tc.mask;
				data_rw = 1'b1;
				issue(1);
				wait_for("memory write", 2, bw + 1);
				if (wr_data.size() > bw) begin
					check_word(tc.name, swap_word(tc.data), wr_data[bw]);
					check_word({tc.name, " mask"}, {28'd0, m[0], m[1], m[2], m[3]}, wr_mask[bw]);
					check_order(tc.name, tc.order, wr_order[bw]);
				end
			end
			k_burst: begin
				// Alternate fetch and load with four reads in flight
				for (int k = 0; k < 4; k++) begin
					if (k % 2 == 0) begin
						inst_addr = tc.addr + 32'(k * 16);
						issue(0);
					end else begin
						data_addr = tc.addr + 32'(k * 16);
						data_rw = 1'b0;
						data_order = order_word;
						data_mask = '1;
						issue(1);
					end
				end
				wait_for("burst instruction lines", 0, bi + 2);
				wait_for("burst data lines", 1, bd + 2);
				for (int k = 0; k < 2; k++) begin
					if (inst_got.size() > bi + k)
						check_line({tc.name, " inst"}, line_of(tc.addr + 32'(k * 32)),
							inst_got[bi + k]);
					if (data_got.size() > bd + k)
						check_line({tc.name, " data"}, line_of(tc.addr + 32'(k * 32 + 16)),
							data_got[bd + k]);
				end
			end
			k_iowrite: begin
				io_addr = tc.addr;
				io_wdata = tc.data;
				io_order = tc.order;
				io_rw = 1'b1;
				issue(2);
				if (tc.order == order_word) begin
					wait_for("IO write acknowledge", 3, bv + 1);
					repeat (3) @(negedge bus_clock);
					check_word({tc.name, " ack count"}, 32'd1, 32'(io_valid_n - bv));
					check_word({tc.name, " gci_addr"}, tc.addr, gci_wr_addr);
					check_word({tc.name, " gci_data"}, tc.data, gci_wr_data);
				end else begin
					wait_for("IO fault", 4, bf + 1);
					repeat (3) @(negedge bus_clock);
					check_flag({tc.name, " gci_req"}, 1'b0, gci_req_n != bg);
					check_flag({tc.name, " io_valid"}, 1'b0, io_valid_n != bv);
				end
			end
			default: begin
				io_addr = tc.addr;
				io_order = order_word;
				io_rw = 1'b0;
				// GCI busy holds the read off
				gci_busy = 1'b1;
				io_req = 1'b1;
				repeat (2) @(negedge bus_clock);
				check_flag({tc.name, " io_busy"}, 1'b1, io_busy);
				check_flag({tc.name, " gci_req while busy"}, 1'b0, gci_req);
				gci_busy = 1'b0;
				issue(2);
				wait_for("IO read return", 3, bv + 1);
				check_word(tc.name, tc.addr + 32'h1000, io_got);
			end
		endcase
		if (errors == e0)
			$display("%-14s ok", tc.name);
		else
			$display("%-14s failed", tc.name);
	endtask

	initial begin
		bus_clock = 1'b0;
		reset = 1'b1;
		inst_req = 1'b0;
		inst_addr = '0;
		data_req = 1'b0;
		data_order = order_word;
		data_mask = '0;
		data_rw = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		memory_lock = 1'b0;
		memory_valid = 1'b0;
		memory_rdata = '0;
		io_req = 1'b0;
		io_order = order_word;
		io_rw = 1'b0;
		io_addr = '0;
		io_wdata = '0;
		gci_busy = 1'b0;
		gci_ret_valid = 1'b0;
		gci_ret_data = '0;
		decided = 1'b0;
		gci_pend = 1'b0;
		cyc = 0;
		errors = 0;
		io_valid_n = 0;
		io_fault_n = 0;
		gci_req_n = 0;
		tests[0] = '{"ifetch", k_ifetch, 32'h0000_1000, 32'h0, order_word, 4'hf};
		tests[1] = '{"dwrite_word", k_dwrite, 32'h0000_2000, 32'h1122_3344, order_word, 4'b0011};
		tests[2] = '{"dwrite_half", k_dwrite, 32'h0000_2004, 32'ha1b2_c3d4, order_half, 4'b1100};
		tests[3] = '{"burst", k_burst, 32'h0000_3000, 32'h0, order_word, 4'hf};
		tests[4] = '{"io_write", k_iowrite, 32'h8000_0010, 32'hcafe_0001, order_word, 4'hf};
		tests[5] = '{"io_read", k_ioread, 32'h8000_0020, 32'h0, order_word, 4'hf};
		tests[6] = '{"io_write_half", k_iowrite, 32'h8000_0030, 32'h0000_beef, order_half, 4'h3};
		tests[7] = '{"burst_again", k_burst, 32'h0000_4400, 32'h0, order_word, 4'hf};
		repeat (8) @(posedge bus_clock);
		@(negedge bus_clock);
		reset = 1'b0;
		foreach (tests[i])
			run_test(tests[i]);
		repeat (10) @(negedge bus_clock);
		$display("Tests run %0d, errors %0d", $size(tests), errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: mist_bus_unit.f
+incdir+design
design/mist_bus_pkg.sv
design/mem_pipe_arbiter.sv
design/memory_port.sv
design/io_port.sv
design/mist_bus_unit.sv
bench/mist_bus_unit_assertions.sv
bench/mist_bus_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bus unit testbench with Verilator
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module mist_bus_unit_tb \
	-f mist_bus_unit.f \
	-o mist_bus_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mist_bus_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
	exit 0
fi
exit 1
